// File: src/isaPkg.sv
package isaPkg;

    localparam int dataWidth = 32;
    localparam int addrWidth = 9;
    localparam int memDepth = 512;
    localparam int regCount = 16;
    localparam int regSelWidth = $clog2(regCount);
    localparam int opWidth = 5;
    localparam int constWidth = dataWidth - opWidth - 2 * regSelWidth; // 19 bit immediate

    // Only these five opcodes are executed, anything else acts as halt
    typedef enum logic [opWidth-1:0] {
        opAddi = 5'b00011,
        opAndi = 5'b01011,
        opOri  = 5'b01010,
        opOut  = 5'b10111,
        opHalt = 5'b11011
    } opcode_e;

    // Instruction word layout, MSB first
    typedef struct packed {
        opcode_e                op; // Bits 31..27
        logic [regSelWidth-1:0] ra; // Destination, or source for out
        logic [regSelWidth-1:0] rb; // Source operand
        logic [constWidth-1:0]  c;  // Signed constant
    } instr_s;

endpackage

// File: src/ctrlPkg.sv
package ctrlPkg;

    localparam int stepWidth = 3;
    localparam int busSrcWidth = 2;

    // Control steps of one instruction, stIdle between runs
    typedef enum logic [stepWidth-1:0] {
        stIdle,
        stT0,
        stT1,
        stT2,
        stT3,
        stT4,
        stT5
    } step_e;

    // Driver of the internal bus
    typedef enum logic [busSrcWidth-1:0] {
        srcPc,
        srcMdr,
        srcReg,
        srcZ
    } busSrc_e;

endpackage

// File: src/busCtrlIf.sv
`timescale 1ns/1ps

interface busCtrlIf (
    input logic Clock,
    input logic rstN
);
    import isaPkg::*;
    import ctrlPkg::*;

    step_e   step;    // Current step, for checking only
    busSrc_e busSrc;
    logic    marIn;
    logic    mdrIn;
    logic    irIn;
    logic    yIn;
    logic    zIn;
    logic    pcIn;
    logic    pcClr;   // Start of a run
    logic    regIn;
    logic    outIn;
    logic    incPc;   // ALU adds one to the bus
    opcode_e aluOp;
    logic    regSelA; // ra instead of rb
    opcode_e irOp;    // Back from IR

    modport ctrl (
        output step, busSrc, marIn, mdrIn, irIn, yIn, zIn, pcIn, pcClr, regIn, outIn,
        output incPc, aluOp, regSelA,
        input  irOp
    );

    modport dp (
        input  busSrc, marIn, mdrIn, irIn, yIn, zIn, pcIn, pcClr, regIn, outIn,
        input  incPc, aluOp, regSelA,
        output irOp
    );

    // IR keeps its opcode until the instruction ends
    irOpHeld: assert property (@(posedge Clock) disable iff (!rstN)
        step inside {stT4, stT5} |-> $stable(irOp));

endinterface

// File: src/programMemory.sv
`timescale 1ns/1ps

module programMemory (
    input  logic                         Clock,
    input  logic                         loadEn,
    input  logic [isaPkg::addrWidth-1:0] loadAddr,
    input  logic [isaPkg::dataWidth-1:0] loadData,
    input  logic [isaPkg::addrWidth-1:0] memAddr,
    output logic [isaPkg::dataWidth-1:0] memRdData
);
    import isaPkg::*;

    logic [dataWidth-1:0] mem [memDepth];

    // Program load port, written before a run
    always_ff @(posedge Clock) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end
    end

    assign memRdData = mem[memAddr]; // No read latency, MAR holds the address

    // An unknown address selects no word of the array
    loadInRange: assert property (@(posedge Clock)
        loadEn |-> !$isunknown(loadAddr));

endmodule

// File: src/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer (
    input  logic      Clock,
    input  logic      rstN,
    input  logic      start,
    output logic      busy,
    output logic      halted,
    busCtrlIf.ctrl    bus
);
    import isaPkg::*;
    import ctrlPkg::*;

    step_e step;
    logic  isImm; // addi, andi, ori
    logic  isOut;

    // Opcode decode, only meaningful from T3 on
    assign isImm = bus.irOp inside {opAddi, opAndi, opOri};
    assign isOut = bus.irOp == opOut;

    assign busy = step != stIdle;
    assign bus.step = step;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            step   <= stIdle;
            halted <= 1'b0;
        end else begin
            case (step)
                stIdle: begin
                    if (start) begin
                        step   <= stT0;
                        halted <= 1'b0; // New run clears the last halt
                    end
                end
                stT0: step <= stT1;
                stT1: step <= stT2;
                stT2: step <= stT3;
                stT3: begin
                    if (isImm) begin
                        step <= stT4;
                    end else if (isOut) begin
                        step <= stT0; // out is done after T3
                    end else begin
                        step   <= stIdle; // halt and unknown opcodes
                        halted <= 1'b1;
                    end
                end
                stT4: step <= stT5;
                stT5: step <= stT0;
                default: step <= stIdle;
            endcase
        end
    end

    // Control strobes, one bus driver per step
    always_comb begin
        bus.busSrc  = srcZ;
        bus.marIn   = 1'b0;
        bus.mdrIn   = 1'b0;
        bus.irIn    = 1'b0;
        bus.yIn     = 1'b0;
        bus.zIn     = 1'b0;
        bus.pcIn    = 1'b0;
        bus.pcClr   = 1'b0;
        bus.regIn   = 1'b0;
        bus.outIn   = 1'b0;
        bus.incPc   = 1'b0;
        bus.regSelA = 1'b0;
        bus.aluOp   = bus.irOp;
        case (step)
            stIdle: bus.pcClr = start; // Run starts at address 0
            stT0: begin
                bus.busSrc = srcPc;
                bus.marIn  = 1'b1;
                bus.zIn    = 1'b1;
                bus.incPc  = 1'b1;
            end
            stT1: begin
                bus.busSrc = srcZ;
                bus.pcIn   = 1'b1;
                bus.mdrIn  = 1'b1;
            end
            stT2: begin
                bus.busSrc = srcMdr;
                bus.irIn   = 1'b1;
            end
            stT3: begin
                if (isImm) begin
                    bus.busSrc = srcReg; // rB into Y
                    bus.yIn    = 1'b1;
                end else if (isOut) begin
                    bus.busSrc  = srcReg; // rA to the port
                    bus.regSelA = 1'b1;
                    bus.outIn   = 1'b1;
                end
            end
            stT4: bus.zIn = 1'b1; // Y op C
            stT5: begin
                bus.busSrc  = srcZ;
                bus.regIn   = 1'b1;
                bus.regSelA = 1'b1;
            end
            default: ;
        endcase
    end

    // A start during a run leaves PC alone and the run goes on until halt
    startIgnored: assert property (@(posedge Clock) disable iff (!rstN)
        start && busy |-> !bus.pcClr ##1 (busy || halted));

    pcRegExclusive: assert property (@(posedge Clock) disable iff (!rstN)
        !(bus.pcIn && bus.regIn));

endmodule

// File: src/busDatapath.sv
`timescale 1ns/1ps

module busDatapath (
    input  logic                         Clock,
    input  logic                         rstN,
    busCtrlIf.dp                         bus,
    output logic [isaPkg::addrWidth-1:0] memAddr,
    input  logic [isaPkg::dataWidth-1:0] memRdData,
    output logic [isaPkg::dataWidth-1:0] outData,
    output logic                         outValid
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic [addrWidth-1:0]   pc;
    logic [addrWidth-1:0]   mar;
    logic [dataWidth-1:0]   mdr;
    instr_s                 ir;
    logic [dataWidth-1:0]   y;
    logic [dataWidth-1:0]   z;
    logic [dataWidth-1:0]   regFile [regCount];
    logic [regSelWidth-1:0] regSel;
    logic [dataWidth-1:0]   busData;
    logic [dataWidth-1:0]   constExt;
    logic [dataWidth-1:0]   aluResult;

    assign memAddr  = mar;
    assign bus.irOp = ir.op;
    assign regSel   = bus.regSelA ? ir.ra : ir.rb;
    assign constExt = {{(dataWidth - constWidth){ir.c[constWidth-1]}}, ir.c}; // Sign extend C

    // Bus multiplexer
    always_comb begin
        case (bus.busSrc)
            srcPc:   busData = {{(dataWidth - addrWidth){1'b0}}, pc};
            srcMdr:  busData = mdr;
            srcReg:  busData = regFile[regSel];
            default: busData = z;
        endcase
    end

    // ALU, PC increment during fetch
    always_comb begin
        if (bus.incPc) begin
            aluResult = busData + dataWidth'(1);
        end else begin
            case (bus.aluOp)
                opAndi:  aluResult = y & constExt;
                opOri:   aluResult = y | constExt;
                default: aluResult = y + constExt;
            endcase
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pc       <= '0;
            mar      <= '0;
            mdr      <= '0;
            ir       <= '0;
            y        <= '0;
            z        <= '0;
            outData  <= '0;
            outValid <= 1'b0;
            for (int i = 0; i < regCount; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            if (bus.pcClr) begin
                pc <= '0;
            end else if (bus.pcIn) begin
                pc <= busData[addrWidth-1:0];
            end
            if (bus.marIn) begin
                mar <= busData[addrWidth-1:0];
            end
            if (bus.mdrIn) begin
                mdr <= memRdData; // Word at MAR
            end
            if (bus.irIn) begin
                ir <= instr_s'(busData);
            end
            if (bus.yIn) begin
                y <= busData;
            end
            if (bus.zIn) begin
                z <= aluResult;
            end
            if (bus.regIn) begin
                regFile[regSel] <= busData;
            end
            if (bus.outIn) begin
                outData <= busData;
            end
            outValid <= bus.outIn; // One cycle pulse
        end
    end

    // Only immediate opcodes reach the ALU outside of fetch
    aluOpValid: assert property (@(posedge Clock) disable iff (!rstN)
        bus.zIn && !bus.incPc |-> bus.aluOp inside {opAddi, opAndi, opOri});

endmodule

// File: src/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
    input  logic                         Clock,
    input  logic                         rstN,
    input  logic                         start,
    input  logic                         loadEn,
    input  logic [isaPkg::addrWidth-1:0] loadAddr,
    input  logic [isaPkg::dataWidth-1:0] loadData,
    output logic                         busy,
    output logic                         halted,
    output logic [isaPkg::dataWidth-1:0] outData,
    output logic                         outValid
);
    import isaPkg::*;

    logic [addrWidth-1:0] memAddr;
    logic [dataWidth-1:0] memRdData;

    busCtrlIf busCtrl (
        .Clock (Clock),
        .rstN  (rstN)
    );

    programMemory programMemory_inst (
        .Clock     (Clock),
        .loadEn    (loadEn),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .memAddr   (memAddr),
        .memRdData (memRdData)
    );

    controlSequencer controlSequencer_inst (
        .Clock  (Clock),
        .rstN   (rstN),
        .start  (start),
        .busy   (busy),
        .halted (halted),
        .bus    (busCtrl.ctrl)
    );

    busDatapath busDatapath_inst (
        .Clock     (Clock),
        .rstN      (rstN),
        .bus       (busCtrl.dp),
        .memAddr   (memAddr),
        .memRdData (memRdData),
        .outData   (outData),
        .outValid  (outValid)
    );

    // Program is only loaded between runs
    noLoadWhileBusy: assert property (@(posedge Clock) disable iff (!rstN)
        !(loadEn && busy));

endmodule

// File: test/cpuTests.svh
`ifndef CPU_TESTS_SVH
`define CPU_TESTS_SVH

localparam int addiLen    = 5;
localparam int signedLen  = 8;
localparam int randomLen  = 12 + regCount + 1; // Immediates, outs, halt
localparam int restartLen = 6;

logic [dataWidth-1:0] progWords[$];
logic [dataWidth-1:0] outWords[$];
logic [dataWidth-1:0] expWords[$];
logic [dataWidth-1:0] regModel[regCount] = '{default: '0}; // Registers survive between runs

function automatic int plannedWords();
    return addiLen + signedLen + randomLen + restartLen;
endfunction

function automatic logic [dataWidth-1:0] makeInstr(opcode_e op, int ra, int rb, int c);
    instr_s ins;
    ins.op = op;
    ins.ra = ra[regSelWidth-1:0];
    ins.rb = rb[regSelWidth-1:0];
    ins.c  = c[constWidth-1:0]; // Keeps the low 19 bits of a negative value
    return ins;
endfunction

task automatic loadProgram();
    foreach (progWords[i]) begin
        @(negedge Clock);
        loadEn   = 1'b1;
        loadAddr = addrWidth'(i);
        loadData = progWords[i];
    end
    @(negedge Clock);
    loadEn = 1'b0;
endtask

// Reference model, walks the program until halt or an unknown opcode
task automatic modelProgram();
    instr_s               ins;
    logic [dataWidth-1:0] cExt;
    expWords.delete();
    foreach (progWords[i]) begin
        ins  = instr_s'(progWords[i]);
        cExt = dataWidth'($signed(ins.c));
        case (ins.op)
            opAddi:  regModel[ins.ra] = regModel[ins.rb] + cExt;
            opAndi:  regModel[ins.ra] = regModel[ins.rb] & cExt;
            opOri:   regModel[ins.ra] = regModel[ins.rb] | cExt;
            opOut:   expWords.push_back(regModel[ins.ra]);
            default: return;
        endcase
    end
endtask

task automatic runUntilHalt();
    outWords.delete();
    @(negedge Clock);
    start = 1'b1;
    @(negedge Clock);
    start = 1'b0;
    checkValue("busy", busy, 1'b1);
    while (!halted) begin
        @(negedge Clock);
        if (outValid) begin
            outWords.push_back(outData);
        end
    end
    checkValue("busy", busy, 1'b0);
endtask

task automatic executeAndCompare();
    loadProgram();
    modelProgram();
    runUntilHalt();
    checkValue("out word count", outWords.size(), expWords.size());
    foreach (expWords[i]) begin
        checkValue($sformatf("outData word %0d", i), outWords[i], expWords[i]);
    end
    @(negedge Clock);
    checkValue("halted", halted, 1'b1); // Level holds after the run
    checkValue("busy", busy, 1'b0);
endtask

task automatic checkAfterReset();
    @(negedge Clock);
    checkValue("busy", busy, 1'b0);
    checkValue("halted", halted, 1'b0);
    checkValue("outValid", outValid, 1'b0);
    checkValue("outData", outData, '0);
endtask

task automatic addiChain();
    progWords = '{makeInstr(opAddi, 1, 0, 20), makeInstr(opAddi, 2, 1, 1),
                  makeInstr(opOut, 1, 0, 0), makeInstr(opOut, 2, 0, 0),
                  makeInstr(opHalt, 0, 0, 0)};
    executeAndCompare();
    checkValue("outData word 0", outWords[0], 32'd20);
    checkValue("outData word 1", outWords[1], 32'd21);
endtask

// Negative constants exercise the sign extension of C
task automatic signedConstants();
    progWords = '{makeInstr(opAddi, 3, 0, 4663), makeInstr(opAndi, 4, 3, -4),
                  makeInstr(opOri, 5, 0, -65536), makeInstr(opAddi, 6, 5, -1),
                  makeInstr(opOut, 4, 0, 0), makeInstr(opOut, 5, 0, 0),
                  makeInstr(opOut, 6, 0, 0), makeInstr(opHalt, 0, 0, 0)};
    executeAndCompare();
    checkValue("outData word 0", outWords[0], 32'h0000_1234);
    checkValue("outData word 1", outWords[1], 32'hFFFF_0000);
endtask

task automatic randomImmediates();
    logic [31:0] r;
    opcode_e     op;
    progWords.delete();
    repeat (12) begin
        r = nextRand();
        case ((r >> 16) % 3)
            0:       op = opAddi;
            1:       op = opAndi;
            default: op = opOri;
        endcase
        progWords.push_back(makeInstr(op, int'(r[27:24]), int'(r[23:20]), int'(nextRand() >> 13)));
    end
    for (int i = 0; i < regCount; i++) begin
        progWords.push_back(makeInstr(opOut, i, 0, 0)); // Dump every register
    end
    progWords.push_back(makeInstr(opHalt, 0, 0, 0));
    executeAndCompare();
    checkValue("out word count", outWords.size(), regCount);
endtask

// Second run from address 0 on the registers of the last run
task automatic restartWithUnknownOp();
    progWords = '{makeInstr(opOut, 1, 0, 0), makeInstr(opAddi, 2, 2, 5),
                  makeInstr(opOut, 2, 0, 0), {5'b00000, 4'd3, 4'd0, 19'd0},
                  makeInstr(opOut, 3, 0, 0), makeInstr(opHalt, 0, 0, 0)};
    executeAndCompare();
    checkValue("out word count", outWords.size(), 2); // Nothing after the unknown word
endtask

`endif

// File: test/cpuTopTb.sv
`timescale 1ns/1ps

module cpuTopTb;
    import isaPkg::*;

    localparam int marginCycles = 128; // Loading, start and idle cycles

    logic                 Clock;
    logic                 rstN;
    logic                 start;
    logic                 loadEn;
    logic [addrWidth-1:0] loadAddr;
    logic [dataWidth-1:0] loadData;
    logic                 busy;
    logic                 halted;
    logic [dataWidth-1:0] outData;
    logic                 outValid;

    int          cycleCount;
    int          cycleLimit;
    logic [31:0] lcgState;

    cpuTop cpuTop_inst (
        .Clock    (Clock),
        .rstN     (rstN),
        .start    (start),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .busy     (busy),
        .halted   (halted),
        .outData  (outData),
        .outValid (outValid)
    );

    initial Clock = 1'b0;
    always #4 Clock = ~Clock; // 8 ns period

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic checkValue(input string name, input logic [dataWidth-1:0] actual,
                              input logic [dataWidth-1:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Watchdog over the whole run
    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
            $display("Result: FAILED");
            $fatal(1, "Run stopped by the watchdog");
        end
    end

    `include "cpuTests.svh"

    initial begin
        rstN       = 1'b0;
        start      = 1'b0;
        loadEn     = 1'b0;
        loadAddr   = '0;
        loadData   = '0;
        lcgState   = 32'h5938;
        cycleCount = 0;
        cycleLimit = plannedWords() * 6 + marginCycles;
        repeat (4) @(negedge Clock);
        rstN = 1'b1;
        checkAfterReset();
        addiChain();
        signedConstants();
        randomImmediates();
        restartWithUnknownOp();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: list.f
+incdir+test
src/isaPkg.sv
src/ctrlPkg.sv
src/busCtrlIf.sv
src/programMemory.sv
src/controlSequencer.sv
src/busDatapath.sv
src/cpuTop.sv
test/cpuTopTb.sv

// File: Bender.yml
package:
  name: bus_cpu

sources:
  - src/isaPkg.sv
  - src/ctrlPkg.sv
  - src/busCtrlIf.sv
  - src/programMemory.sv
  - src/controlSequencer.sv
  - src/busDatapath.sv
  - src/cpuTop.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/cpuTopTb.sv
